// ==== rtl/bus_pkg.sv ====
// Tagged memory bus types.
// Tag 0 is reserved: no value on the tag lines, refusal on the response.

`include "gp_defines.svh"

package bus_pkg;

    // ----------------------------------------
    // Command opcodes
    // ----------------------------------------
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_e;

    // ----------------------------------------
    // Tags, address and data
    // ----------------------------------------
    typedef logic [`GP_TAG_WIDTH-1:0] mem_tag_t;
    typedef logic [`GP_XLEN-1:0]      bus_addr_t;
    typedef logic [`GP_MEM_WIDTH-1:0] bus_data_t;

    // Reserved tag value
    localparam mem_tag_t TAG_NONE = '0;

endpackage

// ==== rtl/event_queue.sv ====
// Coalescing event queue, one entry per vertex, split into bins.
// Events are always accepted. Same-vertex deltas are summed in place.
// One dispatch per cycle, bins served round robin, lowest row first.

`timescale 1ns/100ps

`include "gp_defines.svh"

module event_queue (
    input  logic                  clock,
    input  logic                  rst_i,
    // Event strobe in
    input  logic                  event_valid_i,
    input  graph_pkg::vertex_idx_t event_idx_i,
    input  graph_pkg::delta_t     event_delta_i,
    // Dispatch to the update engine
    input  logic                  upd_ready_i,
    output logic                  disp_valid_o,
    output graph_pkg::vertex_idx_t disp_idx_o,
    output graph_pkg::delta_t     disp_delta_o,
    output logic                  queue_empty_o
);

    import graph_pkg::*;

    // ----------------------------------------
    // Entry storage
    // ----------------------------------------
    // Valid bits per bin and row
    logic [`GP_BIN_NUM-1:0][`GP_ROW_NUM-1:0] ent_valid_q;
    // Coalesced deltas
    delta_t ent_delta_q [`GP_BIN_NUM][`GP_ROW_NUM];

    // Bin served last, search starts after it
    bin_idx_t last_bin_q;

    // Incoming event position
    bin_idx_t ev_bin;
    row_idx_t ev_row;

    // Search result
    logic     found;
    bin_idx_t pick_bin;
    row_idx_t pick_row;
    logic     disp_fire;
    logic     hit_disp;

    assign ev_bin = vtx_bin(event_idx_i);
    assign ev_row = vtx_row(event_idx_i);

    // ----------------------------------------
    // Round-robin bin search
    // ----------------------------------------
    always_comb
    begin : search
        bin_idx_t cand;
        found    = 1'b0;
        pick_bin = last_bin_q;
        pick_row = '0;
        cand     = last_bin_q;
        for (int off = 1; off <= `GP_BIN_NUM; off++)
        begin
            // Wraps at the bin count
            cand = bin_idx_t'(last_bin_q + off);
            if (!found && (|ent_valid_q[cand]))
            begin
                found    = 1'b1;
                pick_bin = cand;
                // Walk down so the lowest valid row is kept
                for (int r = `GP_ROW_NUM - 1; r >= 0; r--)
                begin
                    if (ent_valid_q[cand][r])
                    begin
                        pick_row = row_idx_t'(r);
                    end
                end
            end
        end
    end

    // Dispatch only into an idle engine
    assign disp_fire = found && upd_ready_i;

    // Event lands on the entry leaving this cycle
    assign hit_disp = disp_fire && (pick_bin == ev_bin) && (pick_row == ev_row);

    // ----------------------------------------
    // Control state
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (rst_i)
        begin
            ent_valid_q <= '0;
            // First search then begins at bin 0
            last_bin_q  <= bin_idx_t'(`GP_BIN_NUM - 1);
        end
        else
        begin
            if (disp_fire)
            begin
                ent_valid_q[pick_bin][pick_row] <= 1'b0;
                last_bin_q                      <= pick_bin;
            end
            // Set wins over the dispatch clear
            if (event_valid_i)
            begin
                ent_valid_q[ev_bin][ev_row] <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Delta payload
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (event_valid_i)
        begin
            if (ent_valid_q[ev_bin][ev_row] && !hit_disp)
            begin
                // Coalesce, 16-bit wrap
                ent_delta_q[ev_bin][ev_row] <= ent_delta_q[ev_bin][ev_row] + event_delta_i;
            end
            else
            begin
                // Fresh entry
                ent_delta_q[ev_bin][ev_row] <= event_delta_i;
            end
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    assign disp_valid_o  = disp_fire;
    assign disp_idx_o    = vtx_join(pick_bin, pick_row);
    assign disp_delta_o  = ent_delta_q[pick_bin][pick_row];
    assign queue_empty_o = ~|ent_valid_q;

    // Engine must drop ready right after taking a dispatch
    a_disp_handshake : assert property (
        @(posedge clock) disable iff (rst_i)
        disp_valid_o |=> !upd_ready_i
    );

endmodule

// ==== rtl/gp_defines.svh ====
// Sizes for the event queue, vertex values and the memory bus.
// Vertex index width must equal bin plus row index widths.
// GP_BIN_NUM and GP_ROW_NUM must be powers of two.

`ifndef GP_DEFINES_SVH
`define GP_DEFINES_SVH

// ----------------------------------------
// Event queue geometry
// ----------------------------------------
`define GP_BIN_NUM          4
`define GP_ROW_NUM          8
`define GP_BIN_IDX_WIDTH    2
`define GP_ROW_IDX_WIDTH    3
// Upper bits pick the bin, lower bits the row
`define GP_VERTEX_IDX_WIDTH (`GP_BIN_IDX_WIDTH + `GP_ROW_IDX_WIDTH)

// Vertex values and deltas share one width
`define GP_DELTA_WIDTH      16

// ----------------------------------------
// Memory bus
// ----------------------------------------
`define GP_XLEN             32
`define GP_MEM_WIDTH        64
`define GP_TAG_WIDTH        4

`endif

// ==== rtl/graph_pkg.sv ====
// Graph side types shared by the queue, the update engine and the top.
// Deltas are signed and wrap on overflow.

`include "gp_defines.svh"

package graph_pkg;

    // Vertex number and its two halves
    typedef logic [`GP_VERTEX_IDX_WIDTH-1:0] vertex_idx_t;
    typedef logic [`GP_BIN_IDX_WIDTH-1:0]    bin_idx_t;
    typedef logic [`GP_ROW_IDX_WIDTH-1:0]    row_idx_t;

    // Vertex value or delta, two's complement
    typedef logic signed [`GP_DELTA_WIDTH-1:0] delta_t;

    // Read-modify-write engine states
    typedef enum logic [2:0] {
        UPD_IDLE  = 3'd0,
        UPD_LOAD  = 3'd1,
        UPD_WAIT  = 3'd2,
        UPD_STORE = 3'd3
    } upd_state_e;

    // Bin is taken from the high bits
    function automatic bin_idx_t vtx_bin(vertex_idx_t idx);
        return idx[`GP_VERTEX_IDX_WIDTH-1 -: `GP_BIN_IDX_WIDTH];
    endfunction

    function automatic row_idx_t vtx_row(vertex_idx_t idx);
        return idx[`GP_ROW_IDX_WIDTH-1:0];
    endfunction

    function automatic vertex_idx_t vtx_join(bin_idx_t bin, row_idx_t row);
        return {bin, row};
    endfunction

endpackage

// ==== rtl/graph_pulse.sv ====
// Event-driven vertex update core.
// Events enter on a strobe with no back-pressure.
// Vertex values live in external tagged memory, word per vertex.

`timescale 1ns/100ps

module graph_pulse (
    input  logic                   clock,
    input  logic                   rst_i,
    // Event input
    input  logic                   event_valid_i,
    input  graph_pkg::vertex_idx_t event_idx_i,
    input  graph_pkg::delta_t      event_delta_i,
    output logic                   idle_o,
    // Vertex memory bus
    output bus_pkg::bus_command_e  mem_command_o,
    output bus_pkg::bus_addr_t     mem_addr_o,
    output bus_pkg::bus_data_t     mem_st_data_o,
    input  bus_pkg::mem_tag_t      mem_response_i,
    input  bus_pkg::bus_data_t     mem_ld_data_i,
    input  bus_pkg::mem_tag_t      mem_tag_i
);

    import graph_pkg::*;

    // ----------------------------------------
    // Queue to engine
    // ----------------------------------------
    logic        upd_ready;
    logic        disp_valid;
    vertex_idx_t disp_idx;
    delta_t      disp_delta;
    logic        queue_empty;

    // Engine to tracker
    logic        req_load;
    logic        req_store;
    vertex_idx_t req_idx;
    delta_t      req_value;
    logic        req_accepted;
    logic        ld_valid;
    delta_t      ld_value;

    event_queue i_event_queue (
        .clock         (clock),
        .rst_i         (rst_i),
        .event_valid_i (event_valid_i),
        .event_idx_i   (event_idx_i),
        .event_delta_i (event_delta_i),
        .upd_ready_i   (upd_ready),
        .disp_valid_o  (disp_valid),
        .disp_idx_o    (disp_idx),
        .disp_delta_o  (disp_delta),
        .queue_empty_o (queue_empty)
    );

    vertex_update i_vertex_update (
        .clock          (clock),
        .rst_i          (rst_i),
        .disp_valid_i   (disp_valid),
        .disp_idx_i     (disp_idx),
        .disp_delta_i   (disp_delta),
        .upd_ready_o    (upd_ready),
        .req_load_o     (req_load),
        .req_store_o    (req_store),
        .req_idx_o      (req_idx),
        .req_value_o    (req_value),
        .req_accepted_i (req_accepted),
        .ld_valid_i     (ld_valid),
        .ld_value_i     (ld_value)
    );

    mem_tracker i_mem_tracker (
        .clock          (clock),
        .rst_i          (rst_i),
        .req_load_i     (req_load),
        .req_store_i    (req_store),
        .req_idx_i      (req_idx),
        .req_value_i    (req_value),
        .req_accepted_o (req_accepted),
        .ld_valid_o     (ld_valid),
        .ld_value_o     (ld_value),
        .mem_command_o  (mem_command_o),
        .mem_addr_o     (mem_addr_o),
        .mem_st_data_o  (mem_st_data_o),
        .mem_response_i (mem_response_i),
        .mem_ld_data_i  (mem_ld_data_i),
        .mem_tag_i      (mem_tag_i)
    );

    // Idle once nothing is queued and no update is in flight
    assign idle_o = queue_empty & upd_ready;

endmodule

// ==== rtl/mem_tracker.sv ====
// Owner of the tagged memory bus. One outstanding load at most.
// Commands are suppressed while a load tag is pending.
// Value sits in the low data bits, upper bits zero on stores.

`timescale 1ns/100ps

`include "gp_defines.svh"

module mem_tracker (
    input  logic                   clock,
    input  logic                   rst_i,
    // Requests from the update engine
    input  logic                   req_load_i,
    input  logic                   req_store_i,
    input  graph_pkg::vertex_idx_t req_idx_i,
    input  graph_pkg::delta_t      req_value_i,
    output logic                   req_accepted_o,
    output logic                   ld_valid_o,
    output graph_pkg::delta_t      ld_value_o,
    // Memory bus
    output bus_pkg::bus_command_e  mem_command_o,
    output bus_pkg::bus_addr_t     mem_addr_o,
    output bus_pkg::bus_data_t     mem_st_data_o,
    input  bus_pkg::mem_tag_t      mem_response_i,
    input  bus_pkg::bus_data_t     mem_ld_data_i,
    input  bus_pkg::mem_tag_t      mem_tag_i
);

    import graph_pkg::*;
    import bus_pkg::*;

    // Open load and its tag
    logic     pend_valid_q;
    mem_tag_t pend_tag_q;

    logic     load_accept;
    logic     tag_hit;

    // ----------------------------------------
    // Command issue
    // ----------------------------------------
    always_comb
    begin
        mem_command_o = BUS_NONE;
        if (!pend_valid_q)
        begin
            if (req_load_i)
            begin
                mem_command_o = BUS_LOAD;
            end
            else if (req_store_i)
            begin
                mem_command_o = BUS_STORE;
            end
        end
    end

    // Zero extension of index and value
    assign mem_addr_o    = {{(`GP_XLEN - `GP_VERTEX_IDX_WIDTH){1'b0}}, req_idx_i};
    assign mem_st_data_o = {{(`GP_MEM_WIDTH - `GP_DELTA_WIDTH){1'b0}}, req_value_i};

    // Nonzero response is the tag of the accepted command
    assign req_accepted_o = (mem_command_o != BUS_NONE) && (mem_response_i != TAG_NONE);
    assign load_accept    = req_accepted_o && (mem_command_o == BUS_LOAD);

    // ----------------------------------------
    // Load tag tracking
    // ----------------------------------------
    assign tag_hit = pend_valid_q && (mem_tag_i == pend_tag_q);

    always_ff @(posedge clock)
    begin
        if (rst_i)
        begin
            pend_valid_q <= 1'b0;
        end
        else if (load_accept)
        begin
            pend_valid_q <= 1'b1;
        end
        else if (tag_hit)
        begin
            pend_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock)
    begin
        if (load_accept)
        begin
            pend_tag_q <= mem_response_i;
        end
    end

    assign ld_valid_o = tag_hit;
    assign ld_value_o = delta_t'(mem_ld_data_i[`GP_DELTA_WIDTH-1:0]);

    // Engine never asks for a store while its load is still open
    a_no_store_pending : assert property (
        @(posedge clock) disable iff (rst_i)
        req_store_i |-> !pend_valid_q
    );

endmodule

// ==== rtl/vertex_update.sv ====
// Single read-modify-write engine, one vertex update in flight.
// Load and store requests are levels held until accepted.
// The load result arrives as a pulse on ld_valid_i.

`timescale 1ns/100ps

module vertex_update (
    input  logic                   clock,
    input  logic                   rst_i,
    // From the event queue
    input  logic                   disp_valid_i,
    input  graph_pkg::vertex_idx_t disp_idx_i,
    input  graph_pkg::delta_t      disp_delta_i,
    output logic                   upd_ready_o,
    // To the memory tracker
    output logic                   req_load_o,
    output logic                   req_store_o,
    output graph_pkg::vertex_idx_t req_idx_o,
    output graph_pkg::delta_t      req_value_o,
    input  logic                   req_accepted_i,
    input  logic                   ld_valid_i,
    input  graph_pkg::delta_t      ld_value_i
);

    import graph_pkg::*;

    upd_state_e  state_q;
    upd_state_e  state_d;

    // Vertex being updated and its pending delta
    vertex_idx_t idx_q;
    delta_t      delta_q;
    // Old value plus delta
    delta_t      sum_q;

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            UPD_IDLE:
            begin
                if (disp_valid_i)
                begin
                    state_d = UPD_LOAD;
                end
            end
            UPD_LOAD:
            begin
                // Held until the bus takes it
                if (req_accepted_i)
                begin
                    state_d = UPD_WAIT;
                end
            end
            UPD_WAIT:
            begin
                if (ld_valid_i)
                begin
                    state_d = UPD_STORE;
                end
            end
            UPD_STORE:
            begin
                if (req_accepted_i)
                begin
                    state_d = UPD_IDLE;
                end
            end
            default:
            begin
                state_d = UPD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (rst_i)
        begin
            state_q <= UPD_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        // Latch the dispatched event
        if ((state_q == UPD_IDLE) && disp_valid_i)
        begin
            idx_q   <= disp_idx_i;
            delta_q <= disp_delta_i;
        end
        // Wrapped add on load return
        if ((state_q == UPD_WAIT) && ld_valid_i)
        begin
            sum_q <= ld_value_i + delta_q;
        end
    end

    assign upd_ready_o = (state_q == UPD_IDLE);
    assign req_load_o  = (state_q == UPD_LOAD);
    assign req_store_o = (state_q == UPD_STORE);
    assign req_idx_o   = idx_q;
    assign req_value_o = sum_q;

    // Load data returns only while the engine waits for it
    a_ld_in_wait : assert property (
        @(posedge clock) disable iff (rst_i)
        ld_valid_i |-> (state_q == UPD_WAIT)
    );

    // Tracker acks only an open request
    a_accept_in_req : assert property (
        @(posedge clock) disable iff (rst_i)
        req_accepted_i |-> (state_q inside {UPD_LOAD, UPD_STORE})
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_graph_pulse \
    -f tb.f > build.log 2>&1 \
    && ./obj_dir/Vtb_graph_pulse > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== tb.f ====
+incdir+rtl
rtl/graph_pkg.sv
rtl/bus_pkg.sv
rtl/event_queue.sv
rtl/vertex_update.sv
rtl/mem_tracker.sv
rtl/graph_pulse.sv
tb/tb_graph_pulse.sv

// ==== tb/graph_pulse_patterns.txt ====
# Columns: T name | I vertex value | E vertex delta | S cycles | W (wait idle, compare)
# Numbers are hex, values and deltas are 16-bit two's complement
T single
I 05 0010
E 05 0003
W
T all_bins
I 01 0100
I 0a 0200
I 12 0300
I 1f 0400
E 01 0001
E 0a 0002
E 12 0003
E 1f 0004
E 01 0010
W
T coalesce
I 07 0000
S 20
E 07 0001
E 07 0002
E 07 0004
E 07 0008
E 07 0010
W
T signed_wrap
I 03 7ff0
E 03 0020
E 13 8000
E 13 ffff
W
T mixed
E 00 0001
E 1b fffe
E 09 0100
E 00 0002
E 14 8001
E 1b 0003
E 0e 00ff
E 09 ff00
E 1d 1234
E 06 7fff
E 06 0001
W

// ==== tb/tb_graph_pulse.sv ====
// Testbench for the event-driven vertex update core.
// Stimulus comes from tb/graph_pulse_patterns.txt, numbers in hex.
// Memory model holds 32 vertex words, offers tags 1 to 15 and refuses at random.
// Give at most one S line between two W lines.

`timescale 1ns/100ps

`include "gp_defines.svh"

module tb_graph_pulse;

    import graph_pkg::*;
    import bus_pkg::*;

    localparam int VTX_NUM = `GP_BIN_NUM * `GP_ROW_NUM;

    logic          clock = 1'b0;
    logic          rst_i;
    logic          event_valid_i;
    vertex_idx_t   event_idx_i;
    delta_t        event_delta_i;
    logic          idle_o;
    bus_command_e  mem_command_o;
    bus_addr_t     mem_addr_o;
    bus_data_t     mem_st_data_o;
    mem_tag_t      mem_response_i;
    bus_data_t     mem_ld_data_i;
    mem_tag_t      mem_tag_i;

    // Memory model and reference values
    delta_t        mem [VTX_NUM];
    delta_t        exp_val [VTX_NUM];
    int            store_cnt [VTX_NUM];
    int            ev_cnt [VTX_NUM];
    // Events sent while no stall was active
    int            ev_free [VTX_NUM];
    logic [31:0]   lcg_state;
    mem_tag_t      next_tag;
    mem_tag_t      ld_tag;
    logic [4:0]    ld_slot;
    int            ld_cnt;
    int            stall_cnt;
    logic          idle_s;

    // Parsed pattern operations
    logic [7:0]    op_kind [$];
    logic [31:0]   op_a [$];
    logic [31:0]   op_b [$];
    logic [127:0]  op_name [$];

    logic [127:0]  test_name;
    int            test_errs;
    int            errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            cycle_cnt = 0;
    int            cycle_limit = 0;

    graph_pulse i_graph_pulse (
        .clock          (clock),
        .rst_i          (rst_i),
        .event_valid_i  (event_valid_i),
        .event_idx_i    (event_idx_i),
        .event_delta_i  (event_delta_i),
        .idle_o         (idle_o),
        .mem_command_o  (mem_command_o),
        .mem_addr_o     (mem_addr_o),
        .mem_st_data_o  (mem_st_data_o),
        .mem_response_i (mem_response_i),
        .mem_ld_data_i  (mem_ld_data_i),
        .mem_tag_i      (mem_tag_i)
    );

    always #50 clock = ~clock;

    // Run length guard, 60 cycles per pattern line
    always @(posedge clock)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit))
        begin
            $display("Timeout after %0d cycles, the core never went idle", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Start value of a memory word, uses every address bit
    function automatic delta_t fill_value(input vertex_idx_t a);
        return {3'b101, a, 3'b011, a};
    endfunction

    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errs == 0)
        begin
            $display("test %0s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %0s: %0d errors", test_name, test_errs);
        end
    endtask

    task automatic read_patterns();
        int           fd;
        int           c;
        int           n;
        int           want;
        logic [7:0]   ch;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [127:0] name;
        fd = $fopen("tb/graph_pulse_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Pattern file tb/graph_pulse_patterns.txt could not be opened");
            count_error();
        end
        else
        begin
            c = $fgetc(fd);
            while (c != -1)
            begin
                ch = c[7:0];
                a = '0;
                b = '0;
                name = '0;
                if (ch == "#")
                begin
                    // Skip the rest of a comment line
                    while ((c != -1) && (c != 10))
                    begin
                        c = $fgetc(fd);
                    end
                end
                else if ((ch == "T") || (ch == "I") || (ch == "E") || (ch == "S")
                         || (ch == "W"))
                begin
                    n    = 0;
                    want = 0;
                    if (ch == "T")
                    begin
                        want = 1;
                        n    = $fscanf(fd, "%s", name);
                    end
                    else if ((ch == "I") || (ch == "E"))
                    begin
                        want = 2;
                        n    = $fscanf(fd, "%h %h", a, b);
                    end
                    else if (ch == "S")
                    begin
                        want = 1;
                        n    = $fscanf(fd, "%h", a);
                    end
                    if (n != want)
                    begin
                        $display("Pattern line %c is missing its arguments", ch);
                        count_error();
                    end
                    op_kind.push_back(ch);
                    op_a.push_back(a);
                    op_b.push_back(b);
                    op_name.push_back(name);
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------
    // One clock of stimulus and memory model
    // ----------------------------------------
    task automatic clock_cycle(input logic ev_v, input vertex_idx_t ev_idx,
                               input delta_t ev_delta);
        bus_command_e cmd_s;
        bus_addr_t    addr_s;
        bus_data_t    st_s;
        logic [4:0]   slot;
        logic         refuse;
        // Outputs are settled mid-cycle
        @(negedge clock);
        cmd_s  = mem_command_o;
        addr_s = mem_addr_o;
        st_s   = mem_st_data_o;
        idle_s = idle_o;
        @(posedge clock);
        slot = addr_s[4:0];
        // Load return, upper data bits are noise
        mem_tag_i     <= TAG_NONE;
        mem_ld_data_i <= {lcg_state, lcg_state};
        if (ld_cnt > 0)
        begin
            ld_cnt--;
            if (ld_cnt == 0)
            begin
                mem_tag_i     <= ld_tag;
                mem_ld_data_i <= {lcg_state, lcg_state[15:0], mem[ld_slot]};
            end
        end
        // Accepted in this cycle if our offered tag was nonzero
        if ((cmd_s != BUS_NONE) && (mem_response_i != TAG_NONE))
        begin
            assert (addr_s < 32'(VTX_NUM))
            else
            begin
                $display("Memory command to address %h outside the vertex range", addr_s);
                count_error();
            end
            if (cmd_s == BUS_LOAD)
            begin
                assert (ld_cnt == 0)
                else
                begin
                    $display("Second load accepted while a load was still open");
                    count_error();
                end
                ld_tag    = mem_response_i;
                ld_slot   = slot;
                lcg_state = lcg_next(lcg_state);
                ld_cnt    = 1 + int'(lcg_state[17:16]);
            end
            else
            begin
                assert (st_s[63:16] == '0)
                else
                begin
                    $display("Store to vertex %0d carries nonzero upper data bits", slot);
                    count_error();
                end
                mem[slot] = st_s[15:0];
                store_cnt[slot]++;
            end
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
        if (stall_cnt > 0)
        begin
            stall_cnt--;
        end
        // Event strobe and reference update
        event_valid_i <= ev_v;
        event_idx_i   <= ev_idx;
        event_delta_i <= ev_delta;
        if (ev_v)
        begin
            exp_val[ev_idx] = exp_val[ev_idx] + ev_delta;
            ev_cnt[ev_idx]++;
            if (stall_cnt == 0)
            begin
                ev_free[ev_idx]++;
            end
        end
        // Offer for the next cycle, about one in four refused
        lcg_state = lcg_next(lcg_state);
        refuse = (stall_cnt != 0) || (lcg_state[31:30] == 2'b00);
        mem_response_i <= refuse ? TAG_NONE : next_tag;
    endtask

    task automatic wait_idle();
        // Two cycles so the last event reaches the queue
        clock_cycle(1'b0, '0, '0);
        clock_cycle(1'b0, '0, '0);
        while (!idle_s)
        begin
            clock_cycle(1'b0, '0, '0);
        end
    endtask

    task automatic check_memory();
        for (int v = 0; v < VTX_NUM; v++)
        begin
            assert (mem[v] == exp_val[v])
            else
            begin
                $display("[FAIL] %0s vertex %0d value expected %h actual %h",
                         test_name, v, exp_val[v], mem[v]);
                count_error();
            end
            assert (store_cnt[v] <= ev_cnt[v])
            else
            begin
                $display("[FAIL] %0s vertex %0d stores expected at most %0d actual %0d",
                         test_name, v, ev_cnt[v], store_cnt[v]);
                count_error();
            end
            // All events inside one stall coalesce behind one update
            if ((ev_cnt[v] > 0) && (ev_free[v] == 0))
            begin
                assert (store_cnt[v] <= 2)
                else
                begin
                    $display("[FAIL] %0s vertex %0d stores expected at most 2 actual %0d",
                             test_name, v, store_cnt[v]);
                    count_error();
                end
            end
            store_cnt[v] = 0;
            ev_cnt[v]    = 0;
            ev_free[v]   = 0;
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial
    begin
        logic in_test;
        rst_i          = 1'b1;
        event_valid_i  = 1'b0;
        event_idx_i    = '0;
        event_delta_i  = '0;
        mem_response_i = TAG_NONE;
        mem_ld_data_i  = '0;
        mem_tag_i      = TAG_NONE;
        lcg_state      = 32'hc41;
        next_tag       = 4'd1;
        ld_tag         = TAG_NONE;
        ld_slot        = '0;
        ld_cnt         = 0;
        stall_cnt      = 0;
        idle_s         = 1'b0;
        in_test        = 1'b0;
        for (int v = 0; v < VTX_NUM; v++)
        begin
            mem[v]       = fill_value(vertex_idx_t'(v));
            exp_val[v]   = mem[v];
            store_cnt[v] = 0;
            ev_cnt[v]    = 0;
            ev_free[v]   = 0;
        end
        test_name = "reset";
        test_errs = 0;
        read_patterns();
        cycle_limit = 60 * (op_kind.size() + 1);

        repeat (2) @(posedge clock);
        rst_i <= 1'b0;
        @(negedge clock);
        assert ((idle_o === 1'b1) && (mem_command_o == BUS_NONE))
        else
        begin
            $display("[FAIL] reset idle_o expected 1 actual %b, command expected %0d actual %0d",
                     idle_o, BUS_NONE, mem_command_o);
            count_error();
        end
        close_test();

        for (int i = 0; i < op_kind.size(); i++)
        begin
            case (op_kind[i])
                "T":
                begin
                    if (in_test)
                    begin
                        close_test();
                    end
                    test_name = op_name[i];
                    test_errs = 0;
                    in_test   = 1'b1;
                end
                "I":
                begin
                    mem[op_a[i][4:0]]     = delta_t'(op_b[i]);
                    exp_val[op_a[i][4:0]] = delta_t'(op_b[i]);
                end
                "E": clock_cycle(1'b1, vertex_idx_t'(op_a[i]), delta_t'(op_b[i]));
                "S": stall_cnt = int'(op_a[i]);
                default:
                begin
                    wait_idle();
                    check_memory();
                end
            endcase
        end
        if (in_test)
        begin
            close_test();
        end

        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
